// File: common/stq_config.svh
`ifndef STQ_CONFIG_SVH
`define STQ_CONFIG_SVH

////////////////////
// queue geometry
////////////////////

`define STQ_DEPTH     16  // store queue entries
`define STQ_IDX_W     4   // log2 of depth

////////////////////
// datapath widths
////////////////////

`define STQ_DATA_W    32  // store data word
`define STQ_ADDR_W    16  // word address, no byte offset

// independent load check ports
`define STQ_LD_PORTS  2

`endif

// File: common/stq_ctrl_pkg.sv
package stq_ctrl_pkg;

  ////////////////////
  // forwarding result
  ////////////////////

  typedef enum logic [1:0] {
    FWD_MISS = 2'd0,  // no older store to this word
    FWD_HIT  = 2'd1,  // data valid on fwd_rsp
    FWD_WAIT = 2'd2   // older store not resolved yet
  } fwd_status_e;

  ////////////////////
  // drain FSM
  ////////////////////

  typedef enum logic {
    DRAIN_IDLE  = 1'b0,
    DRAIN_ISSUE = 1'b1   // head goes out at the next edge
  } drain_state_e;

endpackage

// File: common/stq_types_pkg.sv
`include "stq_config.svh"

package stq_types_pkg;

  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;  // entry index
  typedef logic [`STQ_DEPTH-1:0] stq_vec_t;  // one bit per entry

  ////////////////////
  // store side
  ////////////////////

  typedef struct packed {
    logic                   valid;
    stq_idx_t               idx;
    logic [`STQ_ADDR_W-1:0] addr;
  } st_addr_wr_t;

  // one of these per data write port
  typedef struct packed {
    logic                   valid;
    stq_idx_t               idx;
    logic [`STQ_DATA_W-1:0] data;
  } st_data_wr_t;

  ////////////////////
  // load side
  ////////////////////

  typedef struct packed {
    logic                   valid;
    logic [`STQ_ADDR_W-1:0] addr;
    stq_idx_t               tail_snap;  // stores below this are older
  } ld_req_t;

  typedef struct packed {
    logic                      valid;
    stq_ctrl_pkg::fwd_status_e status;
    logic [`STQ_DATA_W-1:0]    data;
  } fwd_rsp_t;

  // address stage result handed to the data stage
  typedef struct packed {
    logic                      valid;
    stq_vec_t                  hit_idx;  // one-hot, zero on miss
    stq_ctrl_pkg::fwd_status_e status;
  } fwd_sel_t;

  typedef struct packed {
    logic                   valid;
    logic [`STQ_ADDR_W-1:0] addr;
    logic [`STQ_DATA_W-1:0] data;
  } mem_wr_t;

endpackage

// File: stq/stq_alloc.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_alloc (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    alloc,
  input  logic                    free_fire,
  output logic                    alloc_fire,
  output stq_types_pkg::stq_idx_t tail,
  output logic                    stq_full
);

  localparam logic [`STQ_IDX_W:0] FULL_CNT = `STQ_DEPTH;

  logic [`STQ_IDX_W:0] count_q;  // one extra bit, holds 0..DEPTH

  assign stq_full   = (count_q == FULL_CNT);
  assign alloc_fire = alloc & ~stq_full;  // alloc on a full queue is dropped

  ////////////////////
  // tail pointer
  ////////////////////

  // depth is a power of two so the tail wraps by itself
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail <= '0;
    end else if (alloc_fire) begin
      tail <= tail + 1'b1;
    end
  end

  ////////////////////
  // occupancy
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      case ({alloc_fire, free_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

endmodule

// File: stq/stq_addr_cam.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_addr_cam (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        alloc_fire,
  input  stq_types_pkg::stq_idx_t     tail,
  input  stq_types_pkg::stq_idx_t     head,
  input  logic                        free_fire,
  input  stq_types_pkg::st_addr_wr_t  st_addr_wr,
  input  stq_types_pkg::ld_req_t      ld_req [`STQ_LD_PORTS],
  output stq_types_pkg::fwd_sel_t     fwd_sel [`STQ_LD_PORTS],
  output logic [`STQ_ADDR_W-1:0]      head_addr
);

  import stq_types_pkg::*;
  import stq_ctrl_pkg::*;

  localparam int unsigned DEPTH = `STQ_DEPTH;
  localparam int unsigned LD    = `STQ_LD_PORTS;

  stq_vec_t               alloc_q;  // entry holds a live store
  stq_vec_t               aval_q;   // address written
  stq_vec_t               alloc_d;
  stq_vec_t               aval_d;
  logic [`STQ_ADDR_W-1:0] addr_q [DEPTH];

  stq_vec_t               hit_oh [LD];
  logic [LD-1:0]          need_wait;

  // entries from head up to snap, head==snap means empty or full
  function automatic stq_vec_t older_mask(input stq_idx_t hd, input stq_idx_t snap,
                                          input stq_vec_t live);
    stq_vec_t m;
    for (int i = 0; i < DEPTH; i++) begin
      if (hd < snap) begin
        m[i] = (i >= hd) && (i < snap);
      end else if (hd > snap) begin
        m[i] = (i >= hd) || (i < snap);
      end else begin
        m[i] = live[hd];
      end
    end
    return m & live;
  endfunction

  // walk down from snap-1, first candidate is the youngest older store
  function automatic stq_vec_t pick_youngest(input stq_vec_t cand, input stq_idx_t snap);
    stq_vec_t oh;
    stq_idx_t idx;
    logic     found;
    oh    = '0;
    found = 1'b0;
    for (int k = 1; k <= DEPTH; k++) begin
      idx = snap - stq_idx_t'(k);
      if (!found && cand[idx]) begin
        oh[idx] = 1'b1;
        found   = 1'b1;
      end
    end
    return oh;
  endfunction

  ////////////////////
  // entry state
  ////////////////////

  always_comb begin
    alloc_d = alloc_q;
    aval_d  = aval_q;
    if (free_fire) begin
      alloc_d[head] = 1'b0;
      aval_d[head]  = 1'b0;
    end
    if (alloc_fire) begin
      alloc_d[tail] = 1'b1;
      aval_d[tail]  = 1'b0;  // address not known yet
    end
    if (st_addr_wr.valid) begin
      aval_d[st_addr_wr.idx] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alloc_q <= '0;
      aval_q  <= '0;
    end else begin
      alloc_q <= alloc_d;
      aval_q  <= aval_d;
    end
  end

  always_ff @(posedge clk) begin
    if (st_addr_wr.valid) begin
      addr_q[st_addr_wr.idx] <= st_addr_wr.addr;
    end
  end

  assign head_addr = addr_q[head];  // for the drain stage

  ////////////////////
  // load match
  ////////////////////

  for (genvar p = 0; p < LD; p++) begin : g_port
    stq_vec_t older;
    stq_vec_t match;

    assign older = older_mask(head, ld_req[p].tail_snap, alloc_q);

    always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
        match[i] = aval_q[i] && (addr_q[i] == ld_req[p].addr);
      end
    end

    assign hit_oh[p]    = pick_youngest(older & match, ld_req[p].tail_snap);
    assign need_wait[p] = |(older & ~aval_q);  // some older address still unknown
  end

  // match registered here, data read one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < LD; p++) begin
        fwd_sel[p] <= '0;
      end
    end else begin
      for (int p = 0; p < LD; p++) begin
        fwd_sel[p].valid   <= ld_req[p].valid;
        fwd_sel[p].hit_idx <= hit_oh[p];
        if (need_wait[p]) begin
          fwd_sel[p].status <= FWD_WAIT;
        end else if (|hit_oh[p]) begin
          fwd_sel[p].status <= FWD_HIT;
        end else begin
          fwd_sel[p].status <= FWD_MISS;
        end
      end
    end
  end

endmodule

// File: stq/stq_data_array.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_data_array (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        alloc_fire,
  input  stq_types_pkg::stq_idx_t     tail,
  input  stq_types_pkg::st_data_wr_t  st_data_wr [2],
  input  stq_types_pkg::fwd_sel_t     fwd_sel [`STQ_LD_PORTS],
  input  stq_types_pkg::stq_idx_t     head,
  output stq_types_pkg::fwd_rsp_t     fwd_rsp [`STQ_LD_PORTS],
  output stq_types_pkg::stq_vec_t     data_ready,
  output logic [`STQ_DATA_W-1:0]      head_data
);

  import stq_types_pkg::*;
  import stq_ctrl_pkg::*;

  localparam int unsigned DEPTH    = `STQ_DEPTH;
  localparam int unsigned W        = `STQ_DATA_W;
  localparam int unsigned WR_PORTS = 2;

  logic [W-1:0] data_q [DEPTH];
  stq_vec_t     ready_q;
  stq_vec_t     ready_d;
  stq_vec_t     wr_oh [WR_PORTS];  // decoded write enables

  ////////////////////
  // write ports
  ////////////////////

  always_comb begin
    for (int w = 0; w < WR_PORTS; w++) begin
      wr_oh[w] = '0;
      if (st_data_wr[w].valid) begin
        wr_oh[w][st_data_wr[w].idx] = 1'b1;
      end
    end
  end

  // later port assigned last, so port 1 wins a shared entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      for (int w = 0; w < WR_PORTS; w++) begin
        if (wr_oh[w][i]) begin
          data_q[i] <= st_data_wr[w].data;
        end
      end
    end
  end

  always_comb begin
    ready_d = ready_q;
    if (alloc_fire) begin
      ready_d[tail] = 1'b0;  // fresh entry has no data
    end
    for (int w = 0; w < WR_PORTS; w++) begin
      ready_d = ready_d | wr_oh[w];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= '0;
    end else begin
      ready_q <= ready_d;
    end
  end

  assign data_ready = ready_q;
  assign head_data  = data_q[head];

  ////////////////////
  // check ports
  ////////////////////

  for (genvar p = 0; p < `STQ_LD_PORTS; p++) begin : g_chk
    logic [W-1:0] rd_data;
    logic         rd_ready;

    // and-or across entries, hit_idx is one-hot or zero
    always_comb begin
      rd_data = '0;
      for (int i = 0; i < DEPTH; i++) begin
        rd_data = rd_data | ({W{fwd_sel[p].hit_idx[i]}} & data_q[i]);
      end
    end

    assign rd_ready = |(fwd_sel[p].hit_idx & ready_q);

    // hit on an entry still missing data has to wait
    assign fwd_rsp[p] = '{
      valid:  fwd_sel[p].valid,
      status: (fwd_sel[p].status == FWD_HIT && !rd_ready) ? FWD_WAIT : fwd_sel[p].status,
      data:   rd_data
    };
  end

endmodule

// File: stq/stq_drain.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_drain (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    commit,
  input  logic                    mem_busy,
  input  stq_types_pkg::stq_vec_t data_ready,
  input  logic [`STQ_ADDR_W-1:0]  head_addr,
  input  logic [`STQ_DATA_W-1:0]  head_data,
  output stq_types_pkg::stq_idx_t head,
  output logic                    free_fire,
  output stq_types_pkg::mem_wr_t  mem_wr
);

  import stq_ctrl_pkg::*;

  // pointers carry a wrap bit so sixteen committed is not zero
  logic [`STQ_IDX_W:0]    head_q;
  logic [`STQ_IDX_W:0]    cmt_q;
  drain_state_e           state_q;
  drain_state_e           state_d;
  logic                   head_cmt;
  logic                   can_issue;

  logic                   mem_vld_q;
  logic [`STQ_ADDR_W-1:0] mem_addr_q;
  logic [`STQ_DATA_W-1:0] mem_data_q;

  assign head      = head_q[`STQ_IDX_W-1:0];
  assign head_cmt  = (head_q != cmt_q);  // head is below the commit point
  assign can_issue = head_cmt && data_ready[head] && !mem_busy;
  assign free_fire = (state_q == DRAIN_ISSUE);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    case (state_q)
      DRAIN_IDLE:  state_d = can_issue ? DRAIN_ISSUE : DRAIN_IDLE;
      DRAIN_ISSUE: state_d = DRAIN_IDLE;  // one write per visit
      default:     state_d = DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= DRAIN_IDLE;
      head_q    <= '0;
      cmt_q     <= '0;
      mem_vld_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      mem_vld_q <= free_fire;  // valid for a single cycle
      if (commit) begin
        cmt_q <= cmt_q + 1'b1;
      end
      if (free_fire) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  // payload captured as the entry is freed
  always_ff @(posedge clk) begin
    if (free_fire) begin
      mem_addr_q <= head_addr;
      mem_data_q <= head_data;
    end
  end

  assign mem_wr = '{valid: mem_vld_q, addr: mem_addr_q, data: mem_data_q};

endmodule

// File: hdl/stq_top.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        alloc,
  input  stq_types_pkg::st_addr_wr_t  st_addr_wr,
  input  stq_types_pkg::st_data_wr_t  st_data_wr [2],
  input  stq_types_pkg::ld_req_t      ld_req [`STQ_LD_PORTS],
  input  logic                        commit,
  input  logic                        mem_busy,
  output stq_types_pkg::stq_idx_t     alloc_idx,
  output logic                        stq_full,
  output stq_types_pkg::fwd_rsp_t     fwd_rsp [`STQ_LD_PORTS],
  output stq_types_pkg::mem_wr_t      mem_wr
);

  import stq_types_pkg::*;

  logic                   alloc_fire;
  logic                   free_fire;
  stq_idx_t               head;
  stq_vec_t               data_ready;
  fwd_sel_t               fwd_sel [`STQ_LD_PORTS];
  logic [`STQ_ADDR_W-1:0] head_addr;
  logic [`STQ_DATA_W-1:0] head_data;

  ////////////////////
  // stages
  ////////////////////

  // alloc_idx doubles as the tail for the other stages
  stq_alloc u_alloc (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc      (alloc),
    .free_fire  (free_fire),
    .alloc_fire (alloc_fire),
    .tail       (alloc_idx),
    .stq_full   (stq_full)
  );

  stq_addr_cam u_addr_cam (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_fire (alloc_fire),
    .tail       (alloc_idx),
    .head       (head),
    .free_fire  (free_fire),
    .st_addr_wr (st_addr_wr),
    .ld_req     (ld_req),
    .fwd_sel    (fwd_sel),
    .head_addr  (head_addr)
  );

  stq_data_array u_data_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_fire (alloc_fire),
    .tail       (alloc_idx),
    .st_data_wr (st_data_wr),
    .fwd_sel    (fwd_sel),
    .head       (head),
    .fwd_rsp    (fwd_rsp),
    .data_ready (data_ready),
    .head_data  (head_data)
  );

  stq_drain u_drain (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit     (commit),
    .mem_busy   (mem_busy),
    .data_ready (data_ready),
    .head_addr  (head_addr),
    .head_data  (head_data),
    .head       (head),
    .free_fire  (free_fire),
    .mem_wr     (mem_wr)
  );

endmodule

// File: dv/stq_tb.sv
`timescale 1ns/1ps
`include "stq_config.svh"

module stq_tb;

  import stq_types_pkg::*;
  import stq_ctrl_pkg::*;

  localparam int DEPTH = `STQ_DEPTH;
  localparam int LD    = `STQ_LD_PORTS;
  localparam logic [`STQ_ADDR_W-1:0] BASE_ADDR = 16'h0040;
  localparam logic [`STQ_ADDR_W-1:0] FAR_ADDR  = 16'h0fff;  // never stored to

  logic        clk;
  logic        rst_n;
  logic        alloc;
  st_addr_wr_t st_addr_wr;
  st_data_wr_t st_data_wr [2];
  ld_req_t     ld_req [LD];
  logic        commit;
  logic        mem_busy;
  stq_idx_t    alloc_idx;
  logic        stq_full;
  fwd_rsp_t    fwd_rsp [LD];
  mem_wr_t     mem_wr;

  ////////////////////
  // reference model
  ////////////////////

  logic [`STQ_ADDR_W-1:0] m_addr [DEPTH];
  logic [`STQ_DATA_W-1:0] m_data [DEPTH];
  logic [DEPTH-1:0]       m_aval;
  logic [DEPTH-1:0]       m_ready;
  stq_idx_t               m_head;
  stq_idx_t               m_tail;
  int                     m_count;
  logic [`STQ_ADDR_W+`STQ_DATA_W-1:0] exp_q [$];  // committed stores in order

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     wr_cnt;

  stq_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc      (alloc),
    .st_addr_wr (st_addr_wr),
    .st_data_wr (st_data_wr),
    .ld_req     (ld_req),
    .commit     (commit),
    .mem_busy   (mem_busy),
    .alloc_idx  (alloc_idx),
    .stq_full   (stq_full),
    .fwd_rsp    (fwd_rsp),
    .mem_wr     (mem_wr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d  errors: %0d  memory writes: %0d", chk_cnt, err_cnt, wr_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic tick();
    @(posedge clk);
    #2;  // inputs move shortly after the edge
  endtask

  function automatic logic [`STQ_ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return BASE_ADDR + {14'd0, r[1:0]};  // four words so matches are common
  endfunction

  // youngest older store to the word or wait on any unknown older address
  function automatic void predict(input logic [`STQ_ADDR_W-1:0] a, input stq_idx_t snap,
                                  output fwd_status_e st, output logic [`STQ_DATA_W-1:0] d);
    int       n;
    stq_idx_t idx;
    logic     unknown;
    logic     found;
    logic     rdy;
    n       = (int'(snap) - int'(m_head) + DEPTH) % DEPTH;
    unknown = 1'b0;
    found   = 1'b0;
    rdy     = 1'b0;
    d       = '0;
    if (n == 0 && m_count == DEPTH) begin
      n = DEPTH;
    end
    for (int k = 1; k <= n; k++) begin
      idx = snap - stq_idx_t'(k);
      if (!m_aval[idx]) begin
        unknown = 1'b1;
      end else if (!found && m_addr[idx] == a) begin
        found = 1'b1;
        rdy   = m_ready[idx];
        d     = m_data[idx];
      end
    end
    if (unknown || (found && !rdy)) begin
      st = FWD_WAIT;
    end else if (found) begin
      st = FWD_HIT;
    end else begin
      st = FWD_MISS;
    end
  endfunction

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic do_alloc();
    tick();
    alloc = 1'b1;
    if (m_count < DEPTH) begin
      m_aval[m_tail]  = 1'b0;
      m_ready[m_tail] = 1'b0;
      m_tail          = m_tail + 1'b1;
      m_count++;
    end
    tick();
    alloc = 1'b0;
    @(negedge clk);
    check_eq("alloc_idx", 64'(m_tail), 64'(alloc_idx));
    check_eq("stq_full", 64'(m_count == DEPTH), 64'(stq_full));
  endtask

  task automatic write_addr(input stq_idx_t idx, input logic [`STQ_ADDR_W-1:0] a);
    tick();
    st_addr_wr   = '{valid: 1'b1, idx: idx, addr: a};
    m_addr[idx]  = a;
    m_aval[idx]  = 1'b1;
    tick();
    st_addr_wr.valid = 1'b0;
  endtask

  task automatic write_data(input stq_idx_t i0, input logic [`STQ_DATA_W-1:0] d0,
                            input stq_idx_t i1, input logic [`STQ_DATA_W-1:0] d1);
    tick();
    st_data_wr[0] = '{valid: 1'b1, idx: i0, data: d0};
    st_data_wr[1] = '{valid: 1'b1, idx: i1, data: d1};
    m_data[i0]    = d0;
    m_data[i1]    = d1;  // port 1 last so it wins a shared entry
    m_ready[i0]   = 1'b1;
    m_ready[i1]   = 1'b1;
    tick();
    st_data_wr[0].valid = 1'b0;
    st_data_wr[1].valid = 1'b0;
  endtask

  task automatic do_commit(input stq_idx_t idx);
    tick();
    commit = 1'b1;
    exp_q.push_back({m_addr[idx], m_data[idx]});
    tick();
    commit = 1'b0;
  endtask

  task automatic check_fwd(input int p, input fwd_status_e st, input logic [`STQ_DATA_W-1:0] d);
    check_eq($sformatf("fwd_rsp[%0d].valid", p), 64'(1'b1), 64'(fwd_rsp[p].valid));
    check_eq($sformatf("fwd_rsp[%0d].status", p), 64'(st), 64'(fwd_rsp[p].status));
    if (st == FWD_HIT) begin
      check_eq($sformatf("fwd_rsp[%0d].data", p), 64'(d), 64'(fwd_rsp[p].data));
    end
  endtask

  // one load per port with a shared snapshot
  task automatic load_check(input logic [`STQ_ADDR_W-1:0] a0, input logic [`STQ_ADDR_W-1:0] a1,
                            input stq_idx_t snap);
    fwd_status_e            st0;
    fwd_status_e            st1;
    logic [`STQ_DATA_W-1:0] d0;
    logic [`STQ_DATA_W-1:0] d1;
    predict(a0, snap, st0, d0);
    predict(a1, snap, st1, d1);
    tick();
    ld_req[0] = '{valid: 1'b1, addr: a0, tail_snap: snap};
    ld_req[1] = '{valid: 1'b1, addr: a1, tail_snap: snap};
    tick();
    ld_req[0].valid = 1'b0;
    ld_req[1].valid = 1'b0;
    @(negedge clk);
    check_fwd(0, st0, d0);
    check_fwd(1, st1, d1);
    // response lasts a single cycle
    @(negedge clk);
    check_eq("fwd_rsp[0].valid", 64'(0), 64'(fwd_rsp[0].valid));
    check_eq("fwd_rsp[1].valid", 64'(0), 64'(fwd_rsp[1].valid));
  endtask

  task automatic wait_writes(input int n);
    int t;
    t = 0;
    while (wr_cnt < n && t < 100) begin
      @(posedge clk);
      t++;
    end
    if (wr_cnt < n) begin
      err_cnt++;
      $display("timeout waiting for memory writes, %0d of %0d seen", wr_cnt, n);
    end
  endtask

  ////////////////////
  // memory write monitor
  ////////////////////

  always @(negedge clk) begin : mem_mon
    logic [`STQ_ADDR_W+`STQ_DATA_W-1:0] w;
    if (rst_n && mem_wr.valid) begin
      wr_cnt++;
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("memory write at %0t without a committed store", $time);
      end
      if (exp_q.size() > 0) begin
        w = exp_q.pop_front();
        check_eq("mem_wr.addr", 64'(w[`STQ_ADDR_W+`STQ_DATA_W-1:`STQ_DATA_W]), 64'(mem_wr.addr));
        check_eq("mem_wr.data", 64'(w[`STQ_DATA_W-1:0]), 64'(mem_wr.data));
        m_aval[m_head]  = 1'b0;  // entry freed with the write
        m_ready[m_head] = 1'b0;
        m_head          = m_head + 1'b1;
        m_count--;
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed       = 32'h38db;
    err_cnt    = 0;
    chk_cnt    = 0;
    wr_cnt     = 0;
    m_aval     = '0;
    m_ready    = '0;
    m_head     = '0;
    m_tail     = '0;
    m_count    = 0;
    rst_n      = 1'b0;
    alloc      = 1'b0;
    commit     = 1'b0;
    mem_busy   = 1'b0;
    st_addr_wr = '0;
    st_data_wr[0] = '0;
    st_data_wr[1] = '0;
    ld_req[0]  = '0;
    ld_req[1]  = '0;

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("alloc_idx", 64'(0), 64'(alloc_idx));
    check_eq("stq_full", 64'(0), 64'(stq_full));
    check_eq("fwd_rsp[0].valid", 64'(0), 64'(fwd_rsp[0].valid));
    check_eq("fwd_rsp[1].valid", 64'(0), 64'(fwd_rsp[1].valid));
    check_eq("mem_wr.valid", 64'(0), 64'(mem_wr.valid));

    // eight stores with nothing resolved yet
    for (int i = 0; i < 8; i++) begin
      do_alloc();
    end
    load_check(BASE_ADDR, FAR_ADDR, m_tail);
    for (int i = 0; i < 8; i++) begin
      write_addr(stq_idx_t'(i), rand_addr());
    end
    load_check(m_addr[7], FAR_ADDR, m_tail);  // hit without data and a clean miss

    for (int i = 0; i < 8; i += 2) begin
      write_data(stq_idx_t'(i), $random(seed), stq_idx_t'(i + 1), $random(seed));
    end
    write_data(stq_idx_t'(5), $random(seed), stq_idx_t'(5), $random(seed));

    // every snapshot against every word in use
    for (int s = 1; s <= 8; s++) begin
      for (int a = 0; a < 4; a += 2) begin
        load_check(BASE_ADDR + 16'(a), BASE_ADDR + 16'(a + 1), stq_idx_t'(s));
      end
    end

    // fill up and try one refused alloc
    for (int i = 0; i < 9; i++) begin
      do_alloc();
    end
    for (int i = 8; i < 16; i++) begin
      write_addr(stq_idx_t'(i), rand_addr());
    end
    for (int i = 8; i < 16; i += 2) begin
      write_data(stq_idx_t'(i), $random(seed), stq_idx_t'(i + 1), $random(seed));
    end
    load_check(BASE_ADDR, BASE_ADDR + 16'd3, m_tail);

    // drain held off by memory back-pressure
    tick();
    mem_busy = 1'b1;
    for (int i = 0; i < 4; i++) begin
      do_commit(stq_idx_t'(i));
    end
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_eq("mem_wr.valid", 64'(0), 64'(mem_wr.valid));
    end
    tick();
    mem_busy = 1'b0;
    wait_writes(1);
    @(negedge clk);
    check_eq("stq_full", 64'(0), 64'(stq_full));
    wait_writes(4);
    for (int i = 4; i < 16; i++) begin
      do_commit(stq_idx_t'(i));
    end
    wait_writes(16);
    @(negedge clk);
    check_eq("stq_full", 64'(0), 64'(stq_full));
    check_eq("alloc_idx", 64'(m_tail), 64'(alloc_idx));
    load_check(BASE_ADDR, BASE_ADDR + 16'd1, m_tail);  // empty queue misses

    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule

// File: list.f
+incdir+common
common/stq_ctrl_pkg.sv
common/stq_types_pkg.sv
stq/stq_alloc.sv
stq/stq_addr_cam.sv
stq/stq_data_array.sv
stq/stq_drain.sv
hdl/stq_top.sv
dv/stq_tb.sv

// File: Bender.yml
package:
  name: stq

export_include_dirs:
  - common

sources:
  # packages first, stages, then the top level
  - include_dirs:
      - common
    files:
      - common/stq_ctrl_pkg.sv
      - common/stq_types_pkg.sv
      - stq/stq_alloc.sv
      - stq/stq_addr_cam.sv
      - stq/stq_data_array.sv
      - stq/stq_drain.sv
      - hdl/stq_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - dv/stq_tb.sv
